// File: fix_rx.f
+incdir+hw
hw/fix_stream_pkg.sv
hw/fix_field_pkg.sv
hw/fix_parser.sv
hw/fix_tag_decoder.sv
hw/fix_value_buffer.sv
hw/fix_checksum_checker.sv
hw/fix_rx_top.sv
sim/fix_rx_tb.sv

// File: hw/fix_checksum_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIX checksum checker.
// Byte sum mod 256 against the three-digit tag 10 value.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "fix_consts.svh"

module fix_checksum_checker (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire fix_stream_pkg::parsed_byte_t pbyte_i,
	input  wire fix_field_pkg::fix_field_t    field_i,
	input  wire logic                         field_valid_i,
	output fix_field_pkg::msg_status_t        status_o,
	output logic                              msg_done_o
);

	logic       in_msg_q;
	logic       last_q;
	logic [7:0] sum_q;
	logic [7:0] sum_nxt;
	logic [7:0] snap_q;
	logic [7:0] count_q;
	logic [7:0] count_fin_q;
	logic [3:0] d0, d1, d2;
	logic       digits_ok;
	logic [9:0] recv;
	logic       sum_ok;

	assign sum_nxt = sum_q + pbyte_i.data;

	// Control. The field after msg_end is the checksum field.
	always_ff @(posedge clk) begin
		if (rst) begin
			in_msg_q <= 1'b0;
			last_q <= 1'b0;
			msg_done_o <= 1'b0;
		end else begin
			last_q <= pbyte_i.msg_end;
			msg_done_o <= last_q && field_valid_i;
			if (pbyte_i.msg_start)
				in_msg_q <= 1'b1;
			else if (pbyte_i.msg_end)
				in_msg_q <= 1'b0;
		end
	end

	// Running sum, per-field snapshot and field count.
	always_ff @(posedge clk) begin
		if (pbyte_i.msg_start) begin
			sum_q <= pbyte_i.data;
			snap_q <= '0;
			count_q <= '0;
		end else if (in_msg_q) begin
			sum_q <= sum_nxt;
			if (pbyte_i.field_end) begin
				count_q <= count_q + 8'd1;
				// Snapshot holds the sum up to the SOH before tag 10.
				if (pbyte_i.msg_end)
					count_fin_q <= count_q + 8'd1;
				else
					snap_q <= sum_nxt;
			end
		end
	end

	// Three ASCII digits of the received checksum.
	assign d0 = field_i.value[3:0];
	assign d1 = field_i.value[11:8];
	assign d2 = field_i.value[19:16];
	assign digits_ok = (field_i.value[7:4] == 4'h3) && (d0 <= 4'd9) &&
		(field_i.value[15:12] == 4'h3) && (d1 <= 4'd9) &&
		(field_i.value[23:20] == 4'h3) && (d2 <= 4'd9);
	assign recv = 10'(d0) * 10'd100 + 10'(d1) * 10'd10 + 10'(d2);

	assign sum_ok = (field_i.tag == `FIX_TAG_W'(`FIX_CKSUM_TAG)) && !field_i.tag_bad &&
		(field_i.len == 5'd3) && digits_ok && (recv == {2'b00, snap_q});

	always_ff @(posedge clk) begin
		if (last_q && field_valid_i) begin
			status_o.checksum_ok <= sum_ok;
			status_o.sum_calc <= snap_q;
			status_o.sum_recv <= recv[7:0];
			status_o.field_count <= count_fin_q;
		end
	end

	// Every verdict traces back to a closing SOH two cycles earlier.
	a_done_after_end: assert property (@(posedge clk) disable iff (rst)
		msg_done_o |-> $past(pbyte_i.msg_end, 2));

endmodule

`default_nettype wire

// File: hw/fix_consts.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIX receive path constants.
// Delimiters, checksum tag and buffer sizing.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FIX_CONSTS_SVH
`define FIX_CONSTS_SVH

// Field delimiter, ASCII SOH.
`define FIX_SOH 8'h01

// Tag/value separator, ASCII "=".
`define FIX_SEP 8'h3d

// Tag number of the trailing checksum field.
`define FIX_CKSUM_TAG 10

// Value bytes kept per field; longer values are truncated.
`define FIX_VAL_DEPTH 16

// Width of the binary tag number.
`define FIX_TAG_W 16

`endif

// File: hw/fix_field_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field-level types of the FIX receive path.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fix_consts.svh"

package fix_field_pkg;

	// One completed tag=value field.
	// Value byte 0 sits in the lowest 8 bits.
	typedef struct packed {
		logic [`FIX_TAG_W-1:0]         tag;
		logic                          tag_bad;
		logic [4:0]                    len;
		logic                          truncated;
		logic [`FIX_VAL_DEPTH*8-1:0]   value;
	} fix_field_t;

	// Result for one message.
	typedef struct packed {
		logic       checksum_ok;
		logic [7:0] sum_calc;
		logic [7:0] sum_recv;
		logic [7:0] field_count;
	} msg_status_t;

endpackage

`default_nettype wire

// File: hw/fix_parser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIX byte classifier.
// Tag/value state machine with registered output.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "fix_consts.svh"

module fix_parser (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic [7:0]              data_i,
	input  wire logic                    new_message_i,
	input  wire logic                    end_message_i,
	output fix_stream_pkg::parsed_byte_t pbyte_o
);

	fix_stream_pkg::parser_state_t state_q;
	fix_stream_pkg::parser_state_t state_d;
	fix_stream_pkg::parsed_byte_t  pbyte_d;

	// Next state and classification of the current byte.
	always_comb begin
		state_d = state_q;
		pbyte_d = '0;
		pbyte_d.data = data_i;
		unique case (state_q)
			fix_stream_pkg::st_idle: begin
				// First byte of a message is already a tag digit.
				if (new_message_i) begin
					pbyte_d.is_tag = 1'b1;
					pbyte_d.msg_start = 1'b1;
					state_d = fix_stream_pkg::st_tag;
				end
			end
			fix_stream_pkg::st_tag: begin
				if (data_i == `FIX_SEP) begin
					if (end_message_i)
						state_d = fix_stream_pkg::st_last_value;
					else
						state_d = fix_stream_pkg::st_value;
				end else begin
					pbyte_d.is_tag = 1'b1;
				end
			end
			fix_stream_pkg::st_value: begin
				if (data_i == `FIX_SOH) begin
					pbyte_d.field_end = 1'b1;
					state_d = fix_stream_pkg::st_tag;
				end else begin
					pbyte_d.is_value = 1'b1;
				end
			end
			fix_stream_pkg::st_last_value: begin
				// SOH here closes the message.
				if (data_i == `FIX_SOH) begin
					pbyte_d.field_end = 1'b1;
					pbyte_d.msg_end = 1'b1;
					state_d = fix_stream_pkg::st_idle;
				end else begin
					pbyte_d.is_value = 1'b1;
				end
			end
			default: state_d = fix_stream_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		pbyte_o.data <= pbyte_d.data;
		if (rst) begin
			state_q <= fix_stream_pkg::st_idle;
			pbyte_o.is_tag <= 1'b0;
			pbyte_o.is_value <= 1'b0;
			pbyte_o.field_end <= 1'b0;
			pbyte_o.msg_start <= 1'b0;
			pbyte_o.msg_end <= 1'b0;
		end else begin
			state_q <= state_d;
			pbyte_o.is_tag <= pbyte_d.is_tag;
			pbyte_o.is_value <= pbyte_d.is_value;
			pbyte_o.field_end <= pbyte_d.field_end;
			pbyte_o.msg_start <= pbyte_d.msg_start;
			pbyte_o.msg_end <= pbyte_d.msg_end;
		end
	end

	// A byte is never both tag and value.
	a_tag_value_excl: assert property (@(posedge clk) disable iff (rst)
		!(pbyte_o.is_tag && pbyte_o.is_value));

	// A field can only close while a value was being read.
	a_field_end_in_value: assert property (@(posedge clk) disable iff (rst)
		pbyte_o.field_end |->
			($past(state_q) inside {fix_stream_pkg::st_value, fix_stream_pkg::st_last_value}));

endmodule

`default_nettype wire

// File: hw/fix_rx_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIX receive top level.
// Parser, tag decoder, value buffer and checksum check.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "fix_consts.svh"

module fix_rx_top (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic [7:0]            data_i,
	input  wire logic                  new_message_i,
	input  wire logic                  end_message_i,
	output fix_field_pkg::fix_field_t  field_o,
	output logic                       field_valid_o,
	output fix_field_pkg::msg_status_t status_o,
	output logic                       msg_done_o
);

	fix_stream_pkg::parsed_byte_t pbyte;
	logic [`FIX_TAG_W-1:0]        tag;
	logic                         tag_bad;

	fix_parser u_parser (
		.clk           (clk),
		.rst           (rst),
		.data_i        (data_i),
		.new_message_i (new_message_i),
		.end_message_i (end_message_i),
		.pbyte_o       (pbyte)
	);

	fix_tag_decoder u_tag_decoder (
		.clk       (clk),
		.rst       (rst),
		.pbyte_i   (pbyte),
		.tag_o     (tag),
		.tag_bad_o (tag_bad)
	);

	fix_value_buffer u_value_buffer (
		.clk           (clk),
		.rst           (rst),
		.pbyte_i       (pbyte),
		.tag_i         (tag),
		.tag_bad_i     (tag_bad),
		.field_o       (field_o),
		.field_valid_o (field_valid_o)
	);

	// Checker looks at the same field the outputs carry.
	fix_checksum_checker u_checksum_checker (
		.clk           (clk),
		.rst           (rst),
		.pbyte_i       (pbyte),
		.field_i       (field_o),
		.field_valid_i (field_valid_o),
		.status_o      (status_o),
		.msg_done_o    (msg_done_o)
	);

endmodule

`default_nettype wire

// File: hw/fix_stream_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte-level types of the FIX receive path.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package fix_stream_pkg;

	// Parser states, same four as the original tag/value machine.
	typedef enum logic [1:0] {
		st_idle       = 2'b00,
		st_tag        = 2'b01,
		st_value      = 2'b10,
		st_last_value = 2'b11
	} parser_state_t;

	// One input byte after classification.
	// field_end and msg_end are set on the closing SOH.
	typedef struct packed {
		logic [7:0] data;
		logic       is_tag;
		logic       is_value;
		logic       field_end;
		logic       msg_start;
		logic       msg_end;
	} parsed_byte_t;

endpackage

`default_nettype wire

// File: hw/fix_tag_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIX tag decoder.
// Decimal tag digits to a binary tag number.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "fix_consts.svh"

module fix_tag_decoder (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire fix_stream_pkg::parsed_byte_t pbyte_i,
	output logic [`FIX_TAG_W-1:0]             tag_o,
	output logic                              tag_bad_o
);

	logic                  in_tag_q;
	logic                  first_byte;
	logic                  is_digit;
	logic [3:0]            digit;
	logic [`FIX_TAG_W-1:0] base;
	logic [`FIX_TAG_W-1:0] tag_next;

	// A tag starts on the message start or after any non-tag byte.
	assign first_byte = pbyte_i.msg_start || !in_tag_q;
	assign is_digit = (pbyte_i.data >= 8'h30) && (pbyte_i.data <= 8'h39);
	assign digit = pbyte_i.data[3:0];
	assign base = first_byte ? '0 : tag_o;

	// base * 10 + digit, shift-add form.
	always_comb begin
		if (is_digit)
			tag_next = (base << 3) + (base << 1) + {{(`FIX_TAG_W-4){1'b0}}, digit};
		else
			tag_next = base;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			in_tag_q <= 1'b0;
			tag_bad_o <= 1'b0;
		end else begin
			in_tag_q <= pbyte_i.is_tag;
			if (pbyte_i.is_tag) begin
				// Sticky within one tag, cleared on the next one.
				tag_bad_o <= (!first_byte && tag_bad_o) || !is_digit;
			end
		end
	end

	// Number holds through the value bytes.
	always_ff @(posedge clk) begin
		if (pbyte_i.is_tag)
			tag_o <= tag_next;
	end

endmodule

`default_nettype wire

// File: hw/fix_value_buffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIX value buffer.
// Collects value bytes and emits each completed field.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "fix_consts.svh"

module fix_value_buffer (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire fix_stream_pkg::parsed_byte_t pbyte_i,
	input  wire logic [`FIX_TAG_W-1:0]        tag_i,
	input  wire logic                         tag_bad_i,
	output fix_field_pkg::fix_field_t         field_o,
	output logic                              field_valid_o
);

	logic [4:0]                  len_q;
	logic                        trunc_q;
	logic [`FIX_VAL_DEPTH*8-1:0] value_q;
	logic                        room;

	assign room = (len_q < 5'(`FIX_VAL_DEPTH));

	// Length and truncation flag of the field being collected.
	always_ff @(posedge clk) begin
		if (rst) begin
			len_q <= '0;
			trunc_q <= 1'b0;
			field_valid_o <= 1'b0;
		end else begin
			field_valid_o <= pbyte_i.field_end;
			if (pbyte_i.field_end) begin
				len_q <= '0;
				trunc_q <= 1'b0;
			end else if (pbyte_i.is_value) begin
				if (room)
					len_q <= len_q + 5'd1;
				else
					trunc_q <= 1'b1;
			end
		end
	end

	// Value bytes, zero beyond len so unused bytes read as 0.
	always_ff @(posedge clk) begin
		if (rst || pbyte_i.field_end)
			value_q <= '0;
		else if (pbyte_i.is_value && room)
			value_q[len_q*8 +: 8] <= pbyte_i.data;
	end

	// Output field, loaded on the closing SOH.
	always_ff @(posedge clk) begin
		if (pbyte_i.field_end) begin
			field_o.tag <= tag_i;
			field_o.tag_bad <= tag_bad_i;
			field_o.len <= len_q;
			field_o.truncated <= trunc_q;
			field_o.value <= value_q;
		end
	end

	// Reported length stays within the buffer and is full when truncated.
	a_len_bound: assert property (@(posedge clk) disable iff (rst)
		field_valid_o |-> (field_o.len <= 5'(`FIX_VAL_DEPTH)) &&
			(!field_o.truncated || (field_o.len == 5'(`FIX_VAL_DEPTH))));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the FIX receive testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fix_rx_tb \
	-f fix_rx.f \
	-o fix_rx_sim

out=$(./obj_dir/fix_rx_sim)
echo "$out"

# Pass only when the testbench printed its pass line.
echo "$out" | grep -q "^SIMULATION PASSED$"

// File: sim/fix_rx_input.txt
# Record: nbytes abort nfields checksum_ok gap(ff = random), then the bytes, all hex.
# Then one line per field: tag tag_bad len truncated value bytes. A 0 0 0 0 0 line ends.
12 0 3 1 ff
33 35 3d 41 01 34 39 3d 41 42 01 31 30 3d 30 32 31 01
23 0 1 0 41
31 0 2 0 41 42
a 0 3 0 30 32 31
c 0 2 0 ff
35 58 3d 37 01 31 30 3d 30 30 33 01
5 1 1 0 37
a 0 3 0 30 30 33
1d 0 2 1 0
35 38 3d 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 01
31 30 3d 32 31 34 01
3a 0 10 1 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50
a 0 3 0 32 31 34
6 1 0 0 ff
33 35 3d 41 42 43
c 0 2 1 0
35 58 3d 37 01 31 30 3d 30 30 32 01
5 1 1 0 37
a 0 3 0 30 30 32
12 0 3 1 0
33 35 3d 41 01 34 39 3d 41 42 01 31 30 3d 30 32 31 01
23 0 1 0 41
31 0 2 0 41 42
a 0 3 0 30 32 31
0 0 0 0 0

// File: sim/fix_rx_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIX receive testbench.
// File-driven messages, field and checksum checks.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "fix_consts.svh"

module fix_rx_tb;

	localparam int max_bytes = 1024;
	localparam int max_recs = 32;
	localparam int max_fields = 128;

	logic clk;
	logic rst;
	logic [7:0] data;
	logic new_msg;
	logic end_msg;
	fix_field_pkg::fix_field_t field;
	logic field_valid;
	fix_field_pkg::msg_status_t status;
	logic msg_done;

	// Stimulus file contents.
	logic [7:0] msg_bytes [max_bytes];
	int rec_first [max_recs];
	int rec_len [max_recs];
	int rec_abort [max_recs];
	int rec_nf [max_recs];
	int rec_ok [max_recs];
	int rec_gap [max_recs];
	int rec_field0 [max_recs];
	int rec_err [max_recs];
	bit rec_done [max_recs];
	logic [`FIX_TAG_W-1:0] fld_tag [max_fields];
	logic fld_bad [max_fields];
	logic [4:0] fld_len [max_fields];
	logic fld_trunc [max_fields];
	logic [`FIX_VAL_DEPTH*8-1:0] fld_value [max_fields];
	int fld_rec [max_fields];
	int n_recs;
	int total_bytes;
	bit loaded;

	int exp_field_q [$];
	int exp_msg_q [$];
	int misc_err;
	logic [31:0] lfsr_state;

	fix_rx_top DUT (
		.clk           (clk),
		.rst           (rst),
		.data_i        (data),
		.new_message_i (new_msg),
		.end_message_i (end_msg),
		.field_o       (field),
		.field_valid_o (field_valid),
		.status_o      (status),
		.msg_done_o    (msg_done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit.
	function automatic logic [7:0] next_random_bits(input int n);
		logic [7:0] r;
		logic fb;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[6:0], fb};
		end
		return r;
	endfunction

	task automatic load_stimulus();
		int fd;
		int code;
		int nb;
		int v;
		int f;
		int k;
		int j;
		int t;
		int b;
		int ln;
		int tr;
		string line;
		fd = $fopen("sim/fix_rx_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open sim/fix_rx_input.txt");
			n_recs = 0;
			total_bytes = 0;
		end else begin
			code = $fgets(line, fd);
			code = $fgets(line, fd);
			n_recs = 0;
			total_bytes = 0;
			f = 0;
			forever begin
				code = $fscanf(fd, "%h %h %h %h %h", nb, rec_abort[n_recs], rec_nf[n_recs],
					rec_ok[n_recs], rec_gap[n_recs]);
				if (code != 5 || nb == 0)
					break;
				rec_first[n_recs] = total_bytes;
				rec_len[n_recs] = nb;
				rec_field0[n_recs] = f;
				for (k = 0; k < nb; k++) begin
					code = $fscanf(fd, "%h", v);
					msg_bytes[total_bytes] = v[7:0];
					total_bytes++;
				end
				for (k = 0; k < rec_nf[n_recs]; k++) begin
					code = $fscanf(fd, "%h %h %h %h", t, b, ln, tr);
					fld_tag[f] = t[`FIX_TAG_W-1:0];
					fld_bad[f] = b[0];
					fld_len[f] = ln[4:0];
					fld_trunc[f] = tr[0];
					fld_value[f] = '0;
					for (j = 0; j < ln; j++) begin
						code = $fscanf(fd, "%h", v);
						fld_value[f][j*8 +: 8] = v[7:0];
					end
					fld_rec[f] = n_recs;
					f++;
				end
				n_recs++;
			end
			$fclose(fd);
		end
	endtask

	// Checksum rule on the stored bytes of one message.
	// The sum covers every byte up to the SOH before the last field,
	// the received value is the three digits after the last "=".
	task automatic expected_sums(input int r, output logic [7:0] calc,
		output logic [7:0] recv);
		int k;
		int last_soh;
		int last_sep;
		int s;
		int d;
		last_soh = -1;
		last_sep = -1;
		for (k = 0; k < rec_len[r] - 1; k++) begin
			if (msg_bytes[rec_first[r] + k] == `FIX_SOH)
				last_soh = k;
			if (msg_bytes[rec_first[r] + k] == `FIX_SEP)
				last_sep = k;
		end
		s = 0;
		for (k = 0; k <= last_soh; k++)
			s = s + int'(msg_bytes[rec_first[r] + k]);
		d = 0;
		for (k = 1; k <= 3; k++)
			d = d * 10 + (int'(msg_bytes[rec_first[r] + last_sep + k]) - 'h30);
		calc = 8'(s % 256);
		recv = 8'(d % 256);
	endtask

	task automatic compare(input string name, input int r, input logic [127:0] exp,
		input logic [127:0] act);
		assert (exp === act) else begin
			$display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
			rec_err[r]++;
		end
	endtask

	task automatic check_field();
		int f;
		int r;
		assert (exp_field_q.size() > 0) else begin
			$display("At %0t field_valid_o pulsed with no field pending", $time);
			misc_err++;
		end
		if (exp_field_q.size() > 0) begin
			f = exp_field_q.pop_front();
			r = fld_rec[f];
			compare("field_o.tag", r, 128'(fld_tag[f]), 128'(field.tag));
			compare("field_o.tag_bad", r, 128'(fld_bad[f]), 128'(field.tag_bad));
			compare("field_o.len", r, 128'(fld_len[f]), 128'(field.len));
			compare("field_o.truncated", r, 128'(fld_trunc[f]), 128'(field.truncated));
			compare("field_o.value", r, 128'(fld_value[f]), 128'(field.value));
		end
	endtask

	task automatic check_status();
		int r;
		logic [7:0] exp_calc;
		logic [7:0] exp_recv;
		assert (exp_msg_q.size() > 0) else begin
			$display("At %0t msg_done_o pulsed with no message pending", $time);
			misc_err++;
		end
		if (exp_msg_q.size() > 0) begin
			r = exp_msg_q.pop_front();
			expected_sums(r, exp_calc, exp_recv);
			compare("status_o.checksum_ok", r, 128'(rec_ok[r]), 128'(status.checksum_ok));
			compare("status_o.sum_calc", r, 128'(exp_calc), 128'(status.sum_calc));
			compare("status_o.sum_recv", r, 128'(exp_recv), 128'(status.sum_recv));
			compare("status_o.field_count", r, 128'(rec_nf[r]), 128'(status.field_count));
			rec_done[r] = 1'b1;
			$display("test %0d: %s", r, (rec_err[r] == 0) ? "ok" : "mismatch");
		end
	endtask

	// Outputs are read at the falling edge, away from the register updates.
	always @(negedge clk) begin
		if (!rst && field_valid)
			check_field();
		if (!rst && msg_done)
			check_status();
	end

	task automatic drive_idle(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			#2;
			data = next_random_bits(8);
			new_msg = 1'b0;
			end_msg = 1'b0;
		end
	endtask

	task automatic drive_record(input int r);
		int k;
		int last_sep;
		int misc_before;
		last_sep = -1;
		for (k = 0; k < rec_len[r]; k++) begin
			if (msg_bytes[rec_first[r] + k] == `FIX_SEP)
				last_sep = k;
		end
		if (rec_abort[r] == 0) begin
			for (k = 0; k < rec_nf[r]; k++)
				exp_field_q.push_back(rec_field0[r] + k);
			exp_msg_q.push_back(r);
		end
		for (k = 0; k < rec_len[r]; k++) begin
			@(posedge clk);
			#2;
			data = msg_bytes[rec_first[r] + k];
			new_msg = (k == 0);
			end_msg = (rec_abort[r] == 0) && (k == last_sep);
		end
		if (rec_abort[r] != 0) begin
			misc_before = misc_err;
			// Close the open field so its strobe is in flight when reset rises.
			@(posedge clk);
			#2;
			data = `FIX_SOH;
			new_msg = 1'b0;
			end_msg = 1'b0;
			@(posedge clk);
			#2;
			rst = 1'b1;
			repeat (2) @(posedge clk);
			#2;
			rst = 1'b0;
			repeat (4) @(posedge clk);
			if (misc_err != misc_before)
				rec_err[r]++;
			rec_done[r] = 1'b1;
			$display("test %0d: %s", r, (rec_err[r] == 0) ? "ok, aborted quietly" : "mismatch");
		end
	endtask

	initial begin
		int r;
		int passed;
		int failed;
		rst = 1'b1;
		data = 8'h00;
		new_msg = 1'b0;
		end_msg = 1'b0;
		misc_err = 0;
		lfsr_state = 32'hc754_e1a2;
		loaded = 1'b0;
		for (r = 0; r < max_recs; r++) begin
			rec_err[r] = 0;
			rec_done[r] = 1'b0;
		end
		load_stimulus();
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		for (r = 0; r < n_recs; r++) begin
			if (rec_gap[r] == 'hff)
				drive_idle(int'(next_random_bits(3)));
			else
				drive_idle(rec_gap[r]);
			drive_record(r);
		end
		drive_idle(1);
		while (exp_field_q.size() > 0 || exp_msg_q.size() > 0)
			@(negedge clk);
		repeat (5) @(posedge clk);
		passed = 0;
		failed = 0;
		for (r = 0; r < n_recs; r++) begin
			if (rec_done[r] && rec_err[r] == 0)
				passed++;
			else
				failed++;
		end
		$display("tests %0d, passed %0d, failed %0d, other errors %0d",
			n_recs, passed, failed, misc_err);
		if (failed == 0 && misc_err == 0 && n_recs > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Bound from the byte count, worst-case gaps and the reset cycles.
	initial begin
		wait (loaded);
		#((total_bytes + n_recs * 13 + 20 + 10) * 20);
		$display("Timeout: the run did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
